// File: build.f
verilog/gfx_color_pkg.sv
verilog/gfx_bus_pkg.sv
verilog/gfx_blend_math.sv
verilog/gfx_blender.sv
verilog/gfx_pixel_fifo.sv
verilog/gfx_render_port.sv
verilog/gfx_blend_top.sv
tb/tb_gfx_blend.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the blend stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx_blend \
  -f build.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
  exit 0
fi
exit 1

// File: tb/tb_gfx_blend.sv
// Testbench for the blend stage: drives fragments, serves target reads and checks output pixels
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_blend;

  localparam int          TOTAL_FRAGS = 72;
  localparam int          TIMEOUT_NS  = TOTAL_FRAGS * 40 * 20 + 16 * 20;
  localparam logic [31:0] MEM_KEY     = 32'h5a3c_96e1;

  logic                        clk_i;
  logic                        rst_i;
  gfx_bus_pkg::gfx_cfg_t       cfg_i;
  logic                        frag_req_i;
  gfx_bus_pkg::gfx_fragment_t  frag_i;
  logic                        frag_ack_o;
  logic                        tgt_req_o;
  logic [31:0]                 tgt_addr_o;
  logic                        tgt_ack_i;
  logic [31:0]                 tgt_data_i;
  logic                        pix_req_o;
  gfx_bus_pkg::gfx_pixel_out_t pix_o;
  logic                        pix_ack_i;

  gfx_bus_pkg::gfx_pixel_out_t exp_q[$];
  logic [31:0]                 exp_addr;
  logic [31:0]                 lfsr_state = 32'hf1fd_f290;
  int                          ack_delay = 0;
  int                          err_count = 0;
  int                          check_count = 0;
  int                          pix_count = 0;
  int                          read_count = 0;

  gfx_blend_top #(
    .FIFO_DEPTH (4)
  ) u_dut (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_i      (cfg_i),
    .frag_req_i (frag_req_i),
    .frag_i     (frag_i),
    .frag_ack_o (frag_ack_o),
    .tgt_req_o  (tgt_req_o),
    .tgt_addr_o (tgt_addr_o),
    .tgt_ack_i  (tgt_ack_i),
    .tgt_data_i (tgt_data_i),
    .pix_req_o  (pix_req_o),
    .pix_o      (pix_o),
    .pix_ack_i  (pix_ack_i)
  );

  always #10 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] target_addr(input gfx_bus_pkg::gfx_cfg_t cfg,
                                              input gfx_bus_pkg::gfx_fragment_t f);
    logic [31:0] index;
    index = 32'(f.y) * 32'(cfg.target_width) + 32'(f.x);
    if (cfg.depth == gfx_color_pkg::DEPTH_RGB888)
      return cfg.target_base + index * 4;
    return cfg.target_base + index * 2;
  endfunction

  function automatic logic [7:0] blend_chan(input int s, input int d, input int a, input int w);
    int sum;
    sum = s * a + d * (255 - a);
    return 8'((sum >> 8) & ((1 << w) - 1));
  endfunction

  // Expected output pixel, target word taken from the responder's address function
  function automatic gfx_bus_pkg::gfx_pixel_out_t ref_pixel(input gfx_bus_pkg::gfx_cfg_t cfg,
                                                           input gfx_bus_pkg::gfx_fragment_t f);
    gfx_bus_pkg::gfx_pixel_out_t p;
    gfx_color_pkg::gfx_pixel_u   dst;
    logic [31:0]                 addr;
    logic [31:0]                 word;
    int                          a;
    p.x     = f.x;
    p.y     = f.y;
    p.z     = f.z;
    p.color = f.color;
    if (cfg.blend_en)
    begin
      addr    = target_addr(cfg, f);
      word    = addr ^ MEM_KEY;
      a       = (int'(f.alpha) * int'(cfg.global_alpha)) >> 8;
      p.color = '0;
      if (cfg.depth == gfx_color_pkg::DEPTH_RGB888)
      begin
        dst = word;
        p.color.v888.r8 = blend_chan(f.color.v888.r8, dst.v888.r8, a, 8);
        p.color.v888.g8 = blend_chan(f.color.v888.g8, dst.v888.g8, a, 8);
        p.color.v888.b8 = blend_chan(f.color.v888.b8, dst.v888.b8, a, 8);
      end
      else
      begin
        dst = addr[1] ? {16'h0000, word[31:16]} : {16'h0000, word[15:0]};
        p.color.v565.lo565.r5 = 5'(blend_chan(f.color.v565.lo565.r5, dst.v565.lo565.r5, a, 5));
        p.color.v565.lo565.g6 = 6'(blend_chan(f.color.v565.lo565.g6, dst.v565.lo565.g6, a, 6));
        p.color.v565.lo565.b5 = 5'(blend_chan(f.color.v565.lo565.b5, dst.v565.lo565.b5, a, 5));
      end
    end
    return p;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_pixel();
    gfx_bus_pkg::gfx_pixel_out_t exp;
    pix_count++;
    assert (exp_q.size() != 0)
    else
    begin
      $display("Output pixel arrived with no fragment pending");
      err_count++;
    end
    if (exp_q.size() != 0)
    begin
      exp = exp_q.pop_front();
      check_value("pix_o.x", {16'h0000, pix_o.x}, {16'h0000, exp.x});
      check_value("pix_o.y", {16'h0000, pix_o.y}, {16'h0000, exp.y});
      check_value("pix_o.z", {16'h0000, pix_o.z}, {16'h0000, exp.z});
      check_value("pix_o.color", pix_o.color, exp.color);
    end
  endtask

  task automatic send_fragment(input gfx_bus_pkg::gfx_fragment_t f);
    exp_q.push_back(ref_pixel(cfg_i, f));
    exp_addr   = target_addr(cfg_i, f);
    frag_i     = f;
    frag_req_i = 1'b1;
    do tick(); while (!frag_ack_o);
    frag_req_i = 1'b0;
    do tick(); while (frag_ack_o);
  endtask

  task automatic run_test(input int id, input string name, input int n,
                          input gfx_bus_pkg::gfx_cfg_t cfg, input logic full_alpha,
                          input int delay);
    gfx_bus_pkg::gfx_fragment_t f;
    int                         errs_before;
    int                         pix_before;
    int                         reads_before;
    errs_before  = err_count;
    pix_before   = pix_count;
    reads_before = read_count;
    cfg_i        = cfg;
    ack_delay    = delay;
    tick();
    for (int i = 0; i < n; i++)
    begin
      f.x     = 16'(rand_bits(10));
      f.y     = 16'(rand_bits(9));
      f.z     = 16'(rand_bits(16));
      f.alpha = full_alpha ? 8'hff : 8'(rand_bits(8));
      f.color = rand_bits(32);
      send_fragment(f);
    end
    // Drain everything still queued or on the output link
    while (exp_q.size() != 0 || pix_req_o || pix_ack_i)
      tick();
    if (!cfg.blend_en)
      assert (read_count == reads_before)
      else
      begin
        $display("Target read issued while blending was disabled");
        err_count++;
      end
    assert (pix_count - pix_before == n)
    else
    begin
      $display("Pixel count %0d does not match fragment count %0d", pix_count - pix_before, n);
      err_count++;
    end
    $display("test %0d %s: %0d fragments, %0d pixels, %0d errors", id, name, n,
             pix_count - pix_before, err_count - errs_before);
  endtask

  // Target memory, answers with a word derived from the address
  initial
  begin
    int delay;
    tgt_ack_i  = 1'b0;
    tgt_data_i = '0;
    forever
    begin
      tick();
      if (tgt_req_o)
      begin
        read_count++;
        check_value("tgt_addr_o", tgt_addr_o, exp_addr);
        delay = 1 + int'(rand_bits(2) % 3);
        repeat (delay) tick();
        tgt_data_i = tgt_addr_o ^ MEM_KEY;
        tgt_ack_i  = 1'b1;
        do tick(); while (tgt_req_o);
        tgt_ack_i = 1'b0;
      end
    end
  end

  // Output link sink and checker
  initial
  begin
    pix_ack_i = 1'b0;
    forever
    begin
      tick();
      if (pix_req_o)
      begin
        check_pixel();
        repeat (ack_delay) tick();
        pix_ack_i = 1'b1;
        do tick(); while (pix_req_o);
        pix_ack_i = 1'b0;
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the DUT stopped responding", TIMEOUT_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    gfx_bus_pkg::gfx_cfg_t cfg;
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    cfg_i      = '0;
    frag_req_i = 1'b0;
    frag_i     = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    cfg = '0;
    cfg.depth = gfx_color_pkg::DEPTH_RGB888;
    run_test(1, "pass-through", 12, cfg, 1'b0, 0);

    cfg.blend_en     = 1'b1;
    cfg.target_base  = 32'h1000_0000;
    cfg.target_width = 16'd640;
    cfg.global_alpha = 8'(rand_bits(8));
    run_test(2, "rgb888 blend", 16, cfg, 1'b0, 0);

    cfg.depth        = gfx_color_pkg::DEPTH_RGB565;
    cfg.target_base  = 32'h0004_0000;
    cfg.target_width = 16'd320;
    run_test(3, "rgb565 blend", 16, cfg, 1'b0, 0);

    cfg.depth        = gfx_color_pkg::DEPTH_RGB888;
    cfg.global_alpha = 8'h00;
    run_test(4, "global alpha zero", 8, cfg, 1'b0, 0);

    // Combined alpha of 254
    cfg.global_alpha = 8'hff;
    run_test(5, "full alpha", 8, cfg, 1'b1, 0);

    cfg.global_alpha = 8'h80;
    run_test(6, "back-pressure", 12, cfg, 1'b0, 30);

    $display("checks %0d, errors %0d, pixels %0d of %0d", check_count, err_count, pix_count,
             TOTAL_FRAGS);
    if (err_count == 0 && pix_count == TOTAL_FRAGS)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/gfx_blend_math.sv
// Blend datapath: unpacks source and target by depth, mixes with combined alpha, repacks
`timescale 1ns/1ps
`default_nettype none

module gfx_blend_math (
  input  gfx_color_pkg::gfx_depth_e depth_i,
  input  gfx_color_pkg::gfx_pixel_u src_i,
  input  gfx_color_pkg::gfx_pixel_u dst_i,
  input  logic [7:0]                alpha_i,
  input  logic [7:0]                global_alpha_i,
  output gfx_color_pkg::gfx_pixel_u color_o
);

  logic [15:0] alpha_prod;
  logic [7:0]  alpha_c;
  logic [7:0]  s_r, s_g, s_b;
  logic [7:0]  d_r, d_g, d_b;
  logic [15:0] mix_r, mix_g, mix_b;

  // src*a + dst*(255-a), never exceeds 255*255
  function automatic logic [15:0] mix(input logic [7:0] s, input logic [7:0] d,
                                      input logic [7:0] a);
    logic [7:0] inv_a;
    inv_a = 8'hff - a;
    return {8'h00, s} * {8'h00, a} + {8'h00, d} * {8'h00, inv_a};
  endfunction

  assign alpha_prod = {8'h00, alpha_i} * {8'h00, global_alpha_i};
  assign alpha_c    = alpha_prod[15:8];

  // Narrow channels are zero extended so one mixer serves both depths
  always_comb
  begin
    if (depth_i == gfx_color_pkg::DEPTH_RGB888)
    begin
      s_r = src_i.v888.r8;
      s_g = src_i.v888.g8;
      s_b = src_i.v888.b8;
      d_r = dst_i.v888.r8;
      d_g = dst_i.v888.g8;
      d_b = dst_i.v888.b8;
    end
    else
    begin
      s_r = {3'b000, src_i.v565.lo565.r5};
      s_g = {2'b00, src_i.v565.lo565.g6};
      s_b = {3'b000, src_i.v565.lo565.b5};
      d_r = {3'b000, dst_i.v565.lo565.r5};
      d_g = {2'b00, dst_i.v565.lo565.g6};
      d_b = {3'b000, dst_i.v565.lo565.b5};
    end
  end

  assign mix_r = mix(s_r, d_r, alpha_c);
  assign mix_g = mix(s_g, d_g, alpha_c);
  assign mix_b = mix(s_b, d_b, alpha_c);

  // Bits [width+7:8] of each sum, pad bits stay zero
  always_comb
  begin
    color_o = '0;
    if (depth_i == gfx_color_pkg::DEPTH_RGB888)
    begin
      color_o.v888.r8 = mix_r[15:8];
      color_o.v888.g8 = mix_g[15:8];
      color_o.v888.b8 = mix_b[15:8];
    end
    else
    begin
      color_o.v565.lo565.r5 = mix_r[12:8];
      color_o.v565.lo565.g6 = mix_g[13:8];
      color_o.v565.lo565.b5 = mix_b[12:8];
    end
  end

endmodule

`default_nettype wire

// File: verilog/gfx_blend_top.sv
// Blend stage top: blender feeding the pixel FIFO, drained by the render port
`timescale 1ns/1ps
`default_nettype none

module gfx_blend_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  gfx_bus_pkg::gfx_cfg_t       cfg_i,
  input  logic                        frag_req_i,
  input  gfx_bus_pkg::gfx_fragment_t  frag_i,
  output logic                        frag_ack_o,
  output logic                        tgt_req_o,
  output logic [31:0]                 tgt_addr_o,
  input  logic                        tgt_ack_i,
  input  logic [31:0]                 tgt_data_i,
  output logic                        pix_req_o,
  output gfx_bus_pkg::gfx_pixel_out_t pix_o,
  input  logic                        pix_ack_i
);

  logic                        push;
  gfx_bus_pkg::gfx_pixel_out_t push_data;
  logic                        full;
  logic                        pop;
  gfx_bus_pkg::gfx_pixel_out_t fifo_data;
  logic                        empty;

  gfx_blender u_blender (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_i       (cfg_i),
    .frag_req_i  (frag_req_i),
    .frag_i      (frag_i),
    .frag_ack_o  (frag_ack_o),
    .tgt_req_o   (tgt_req_o),
    .tgt_addr_o  (tgt_addr_o),
    .tgt_ack_i   (tgt_ack_i),
    .tgt_data_i  (tgt_data_i),
    .push_o      (push),
    .push_data_o (push_data),
    .full_i      (full)
  );

  gfx_pixel_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push),
    .data_i  (push_data),
    .full_o  (full),
    .pop_i   (pop),
    .data_o  (fifo_data),
    .empty_o (empty)
  );

  gfx_render_port u_render (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .empty_i   (empty),
    .data_i    (fifo_data),
    .pop_o     (pop),
    .pix_req_o (pix_req_o),
    .pix_o     (pix_o),
    .pix_ack_i (pix_ack_i)
  );

endmodule

`default_nettype wire

// File: verilog/gfx_blender.sv
// Blender: accepts fragments, fetches the target pixel, blends and pushes into the pixel FIFO
`timescale 1ns/1ps
`default_nettype none

module gfx_blender (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  gfx_bus_pkg::gfx_cfg_t       cfg_i,
  input  logic                        frag_req_i,
  input  gfx_bus_pkg::gfx_fragment_t  frag_i,
  output logic                        frag_ack_o,
  output logic                        tgt_req_o,
  output logic [31:0]                 tgt_addr_o,
  input  logic                        tgt_ack_i,
  input  logic [31:0]                 tgt_data_i,
  output logic                        push_o,
  output gfx_bus_pkg::gfx_pixel_out_t push_data_o,
  input  logic                        full_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_RELEASE,
    ST_PUSH,
    ST_ACK
  } state_e;

  state_e                     state;
  gfx_bus_pkg::gfx_fragment_t frag_q;
  gfx_color_pkg::gfx_pixel_u  dst_q;
  gfx_color_pkg::gfx_pixel_u  blend_color;
  logic [31:0]                pix_index;
  logic [31:0]                byte_offset;
  logic                       accept;
  logic                       read_done;
  logic                       push_now;

  assign accept    = (state == ST_IDLE) && frag_req_i;
  assign read_done = (state == ST_READ) && tgt_ack_i;
  assign push_now  = (state == ST_PUSH) && !full_i;

  // Linear pixel index, then scaled by bytes per pixel
  assign pix_index   = 32'(frag_i.y) * 32'(cfg_i.target_width) + 32'(frag_i.x);
  assign byte_offset = (cfg_i.depth == gfx_color_pkg::DEPTH_RGB888) ?
                       {pix_index[29:0], 2'b00} : {pix_index[30:0], 1'b0};

  gfx_blend_math u_math (
    .depth_i        (cfg_i.depth),
    .src_i          (frag_q.color),
    .dst_i          (dst_q),
    .alpha_i        (frag_q.alpha),
    .global_alpha_i (cfg_i.global_alpha),
    .color_o        (blend_color)
  );

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state      <= ST_IDLE;
      frag_ack_o <= 1'b0;
      tgt_req_o  <= 1'b0;
      push_o     <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (accept)
          begin
            if (cfg_i.blend_en)
            begin
              tgt_req_o <= 1'b1;
              state     <= ST_READ;
            end
            else
              state <= ST_PUSH;
          end
        ST_READ:
          if (read_done)
          begin
            tgt_req_o <= 1'b0;
            state     <= ST_RELEASE;
          end
        // Wait for the memory side to close its handshake
        ST_RELEASE:
          if (!tgt_ack_i)
            state <= ST_PUSH;
        ST_PUSH:
          if (push_now)
          begin
            push_o <= 1'b1;
            state  <= ST_ACK;
          end
        ST_ACK:
        begin
          push_o <= 1'b0;
          if (!frag_ack_o)
            frag_ack_o <= 1'b1;
          else if (!frag_req_i)
          begin
            frag_ack_o <= 1'b0;
            state      <= ST_IDLE;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      frag_q     <= frag_i;
      tgt_addr_o <= cfg_i.target_base + byte_offset;
    end
    // Address bit 1 picks the half-word for 16-bit pixels
    if (read_done)
    begin
      if (cfg_i.depth == gfx_color_pkg::DEPTH_RGB888)
        dst_q <= tgt_data_i;
      else if (tgt_addr_o[1])
        dst_q <= {16'h0000, tgt_data_i[31:16]};
      else
        dst_q <= {16'h0000, tgt_data_i[15:0]};
    end
    if (push_now)
    begin
      push_data_o.x     <= frag_q.x;
      push_data_o.y     <= frag_q.y;
      push_data_o.z     <= frag_q.z;
      push_data_o.color <= cfg_i.blend_en ? blend_color : frag_q.color;
    end
  end

  a_tgt_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    tgt_req_o && $past(tgt_req_o) |-> $stable(tgt_addr_o));

  // Full can only rise through our own push, so the one-cycle-late strobe is safe
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_o |-> !full_i);

endmodule

`default_nettype wire

// File: verilog/gfx_bus_pkg.sv
// Bus package: configuration, fragment and output pixel records carried between blocks
`default_nettype none

package gfx_bus_pkg;

  // Static for the duration of a run
  typedef struct packed {
    logic                      blend_en;
    gfx_color_pkg::gfx_depth_e depth;
    logic [31:0]               target_base;
    logic [15:0]               target_width;
    logic [7:0]                global_alpha;
  } gfx_cfg_t;

  typedef struct packed {
    logic [15:0]               x;
    logic [15:0]               y;
    logic signed [15:0]        z;
    logic [7:0]                alpha;
    gfx_color_pkg::gfx_pixel_u color;
  } gfx_fragment_t;

  // What leaves the blender, minus the alpha
  typedef struct packed {
    logic [15:0]               x;
    logic [15:0]               y;
    logic signed [15:0]        z;
    gfx_color_pkg::gfx_pixel_u color;
  } gfx_pixel_out_t;

  localparam int PIXEL_W = $bits(gfx_pixel_out_t);

endpackage

`default_nettype wire

// File: verilog/gfx_color_pkg.sv
// Colour package: depth encoding, channel layouts and the shared 32-bit pixel word
`default_nettype none

package gfx_color_pkg;

  // One bit picks between the two supported depths
  typedef enum logic {
    DEPTH_RGB565 = 1'b0,
    DEPTH_RGB888 = 1'b1
  } gfx_depth_e;

  typedef struct packed {
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
  } rgb565_t;

  // Top byte is unused
  typedef struct packed {
    logic [7:0] pad8;
    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
  } rgb888_t;

  // RGB565 lives in the low half-word
  typedef struct packed {
    logic [15:0] pad16;
    rgb565_t     lo565;
  } rgb565_word_t;

  // Same word, two decodings; the active depth decides which view is valid
  typedef union packed {
    rgb888_t      v888;
    rgb565_word_t v565;
  } gfx_pixel_u;

endpackage

`default_nettype wire

// File: verilog/gfx_pixel_fifo.sv
// Pixel FIFO: register array of blended pixels with occupancy count, full and empty flags
`timescale 1ns/1ps
`default_nettype none

module gfx_pixel_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        push_i,
  input  gfx_bus_pkg::gfx_pixel_out_t data_i,
  output logic                        full_o,
  input  logic                        pop_i,
  output gfx_bus_pkg::gfx_pixel_out_t data_o,
  output logic                        empty_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [gfx_bus_pkg::PIXEL_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]                   wr_ptr;
  logic [AW-1:0]                   rd_ptr;
  logic [AW:0]                     count;

  assign full_o  = (count == (AW+1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem[wr_ptr] <= data_i;
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      if (push_i && !pop_i)
        count <= count + 1'b1;
      else if (pop_i && !push_i)
        count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: verilog/gfx_render_port.sv
// Render port: pops one pixel at a time and offers it on the output four-phase link
`timescale 1ns/1ps
`default_nettype none

module gfx_render_port (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        empty_i,
  input  gfx_bus_pkg::gfx_pixel_out_t data_i,
  output logic                        pop_o,
  output logic                        pix_req_o,
  output gfx_bus_pkg::gfx_pixel_out_t pix_o,
  input  logic                        pix_ack_i
);

  typedef enum logic [1:0] {
    PS_IDLE,
    PS_REQ,
    PS_DRAIN
  } pstate_e;

  pstate_e state;

  assign pop_o = (state == PS_IDLE) && !empty_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state     <= PS_IDLE;
      pix_req_o <= 1'b0;
    end
    else
    begin
      case (state)
        PS_IDLE:
          if (pop_o)
          begin
            pix_req_o <= 1'b1;
            state     <= PS_REQ;
          end
        PS_REQ:
          if (pix_ack_i)
          begin
            pix_req_o <= 1'b0;
            state     <= PS_DRAIN;
          end
        // Ready again only once the sink has dropped ack
        PS_DRAIN:
          if (!pix_ack_i)
            state <= PS_IDLE;
        default:
          state <= PS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o)
      pix_o <= data_i;
  end

  a_pix_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    pix_req_o && $past(pix_req_o) |-> $stable(pix_o));

endmodule

`default_nettype wire
